// ==== design/ro_cache_geom_pkg.sv ====
// Read-only cache geometry: address, index, tag and data widths and types
package ro_cache_geom_pkg;

  // --------------------------------------
  // Widths and line count
  // --------------------------------------
  // Word address, not byte address
  localparam int unsigned ADDR_W     = 16;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned LINE_COUNT = 16;

  // Index selects a line, tag is everything above it
  localparam int unsigned INDEX_W = $clog2(LINE_COUNT);
  localparam int unsigned TAG_W   = ADDR_W - INDEX_W;

  // --------------------------------------
  // Types
  // --------------------------------------
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;

  // Low address bits
  typedef logic [INDEX_W-1:0] index_t;

  // High address bits
  typedef logic [TAG_W-1:0]   tag_t;

endpackage

// ==== design/ro_cache_ctrl_pkg.sv ====
// Read-only cache control encodings: request route and refill FSM states
package ro_cache_ctrl_pkg;

  // --------------------------------------
  // Request route
  // --------------------------------------
  // Bypass reads go straight to memory and are never stored
  typedef enum logic {
    ROUTE_BYPASS = 1'b0,
    ROUTE_CACHE  = 1'b1
  } route_e;

  // --------------------------------------
  // Refill controller states
  // --------------------------------------
  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_WAIT_MEM = 2'd1,
    ST_RESPOND  = 2'd2
  } ctrl_state_e;

endpackage

// ==== design/lookup_if.sv ====
// Lookup result channel from the line store to the refill controller
`timescale 1ns/100ps

interface lookup_if
  import ro_cache_geom_pkg::*;
  import ro_cache_ctrl_pkg::*;
();

  // One-cycle strobe, no ready
  logic   valid;
  addr_t  addr;
  route_e route;
  // Only meaningful on a cached route
  logic   hit;
  data_t  data;

  modport store (
    output valid, addr, route, hit, data
  );

  modport ctrl (
    input valid, addr, route, hit, data
  );

endinterface

// ==== design/fill_if.sv ====
// Line fill channel from the refill controller to the line store
`timescale 1ns/100ps

interface fill_if
  import ro_cache_geom_pkg::*;
();

  // Store writes the line on the edge that samples valid
  logic   valid;
  index_t index;
  tag_t   tag;
  data_t  data;

  modport ctrl (
    output valid, index, tag, data
  );

  modport store (
    input valid, index, tag, data
  );

endinterface

// ==== design/region_router.sv ====
// Request register that classifies each read as cached or bypassed
`timescale 1ns/100ps

module region_router
  import ro_cache_geom_pkg::*;
  import ro_cache_ctrl_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   enable_i,
  input  addr_t  region_start_i,
  input  addr_t  region_end_i,
  input  logic   req_valid_i,
  input  addr_t  req_addr_i,
  output logic   look_valid_o,
  output addr_t  look_addr_o,
  output route_e look_route_o
);

  logic   in_region;
  route_e route_d;

  // Start inclusive, end exclusive
  assign in_region = (req_addr_i >= region_start_i) && (req_addr_i < region_end_i);

  always_comb begin
    route_d = ROUTE_BYPASS;
    if (enable_i && in_region) begin
      route_d = ROUTE_CACHE;
    end
  end

  // --------------------------------------
  // Request register
  // --------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      look_valid_o <= 1'b0;
    end else begin
      look_valid_o <= req_valid_i;
    end
  end

  // Payload only captured with a request
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      look_addr_o  <= req_addr_i;
      look_route_o <= route_d;
    end
  end

endmodule

// ==== design/line_store.sv ====
// Direct-mapped line store with registered lookup, line fill and flush
`timescale 1ns/100ps

module line_store
  import ro_cache_geom_pkg::*;
  import ro_cache_ctrl_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    flush_i,
  input  logic    look_valid_i,
  input  addr_t   look_addr_i,
  input  route_e  look_route_i,
  fill_if.store   fill,
  lookup_if.store result
);

  logic [LINE_COUNT-1:0] valid_q;
  tag_t                  tag_mem  [LINE_COUNT];
  data_t                 data_mem [LINE_COUNT];

  index_t look_index;
  tag_t   look_tag;

  assign look_index = look_addr_i[INDEX_W-1:0];
  assign look_tag   = look_addr_i[ADDR_W-1:INDEX_W];

  // --------------------------------------
  // Valid bits, fill and flush
  // --------------------------------------
  // Flush wins over a fill in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= '0;
    end else if (fill.valid) begin
      valid_q[fill.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill.valid) begin
      tag_mem[fill.index]  <= fill.tag;
      data_mem[fill.index] <= fill.data;
    end
  end

  // --------------------------------------
  // Lookup stage
  // --------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= look_valid_i;
    end
  end

  // Bypass reads never hit, whatever the arrays hold
  always_ff @(posedge clk_i) begin
    result.addr  <= look_addr_i;
    result.route <= look_route_i;
    result.hit   <= (look_route_i == ROUTE_CACHE) && valid_q[look_index] &&
                    (tag_mem[look_index] == look_tag);
    result.data  <= data_mem[look_index];
  end

endmodule

// ==== design/refill_ctrl.sv ====
// Refill controller that answers hits and fetches misses and bypasses from memory
`timescale 1ns/100ps

module refill_ctrl
  import ro_cache_geom_pkg::*;
  import ro_cache_ctrl_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  lookup_if.ctrl  result,
  input  logic    mem_rsp_valid_i,
  input  data_t   mem_rsp_data_i,
  fill_if.ctrl    fill,
  output logic    rsp_valid_o,
  output data_t   rsp_data_o,
  output logic    mem_req_o,
  output addr_t   mem_addr_o
);

  ctrl_state_e state_q;
  logic        rsp_valid_q;
  logic        mem_req_q;
  logic        fill_valid_q;

  addr_t  addr_q;
  route_e route_q;
  data_t  rsp_data_q;

  // --------------------------------------
  // FSM and strobes
  // --------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= ST_IDLE;
      rsp_valid_q  <= 1'b0;
      mem_req_q    <= 1'b0;
      fill_valid_q <= 1'b0;
    end else begin
      // All strobes last a single cycle
      rsp_valid_q  <= 1'b0;
      mem_req_q    <= 1'b0;
      fill_valid_q <= 1'b0;
      unique case (state_q)
        ST_IDLE: begin
          if (result.valid && result.hit) begin
            rsp_valid_q <= 1'b1;
            state_q     <= ST_RESPOND;
          end else if (result.valid) begin
            mem_req_q <= 1'b1;
            state_q   <= ST_WAIT_MEM;
          end
        end
        ST_WAIT_MEM: begin
          if (mem_rsp_valid_i) begin
            rsp_valid_q  <= 1'b1;
            // Bypassed data is returned but never stored
            fill_valid_q <= (route_q == ROUTE_CACHE);
            state_q      <= ST_RESPOND;
          end
        end
        ST_RESPOND: state_q <= ST_IDLE;
        default:    state_q <= ST_IDLE;
      endcase
    end
  end

  // Address and route held for the whole memory wait
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && result.valid) begin
      addr_q     <= result.addr;
      route_q    <= result.route;
      rsp_data_q <= result.data;
    end else if (state_q == ST_WAIT_MEM && mem_rsp_valid_i) begin
      rsp_data_q <= mem_rsp_data_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_data_q;
  assign mem_req_o   = mem_req_q;
  assign mem_addr_o  = addr_q;

  // Fill goes out together with the response
  assign fill.valid = fill_valid_q;
  assign fill.index = addr_q[INDEX_W-1:0];
  assign fill.tag   = addr_q[ADDR_W-1:INDEX_W];
  assign fill.data  = rsp_data_q;

endmodule

// ==== design/ro_cache_top.sv ====
// Read-only cache top level with a configurable cacheable region
`timescale 1ns/100ps

module ro_cache_top
  import ro_cache_geom_pkg::*;
  import ro_cache_ctrl_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  enable_i,
  input  logic  flush_i,
  input  addr_t region_start_i,
  input  addr_t region_end_i,
  input  logic  req_valid_i,
  input  addr_t req_addr_i,
  input  logic  mem_rsp_valid_i,
  input  data_t mem_rsp_data_i,
  output logic  rsp_valid_o,
  output data_t rsp_data_o,
  output logic  mem_req_o,
  output addr_t mem_addr_o
);

  logic   look_valid;
  addr_t  look_addr;
  route_e look_route;

  lookup_if i_lookup_if ();
  fill_if   i_fill_if ();

  region_router i_router (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .enable_i       ( enable_i       ),
    .region_start_i ( region_start_i ),
    .region_end_i   ( region_end_i   ),
    .req_valid_i    ( req_valid_i    ),
    .req_addr_i     ( req_addr_i     ),
    .look_valid_o   ( look_valid     ),
    .look_addr_o    ( look_addr      ),
    .look_route_o   ( look_route     )
  );

  line_store i_store (
    .clk_i        ( clk_i       ),
    .reset_i      ( reset_i     ),
    .flush_i      ( flush_i     ),
    .look_valid_i ( look_valid  ),
    .look_addr_i  ( look_addr   ),
    .look_route_i ( look_route  ),
    .fill         ( i_fill_if   ),
    .result       ( i_lookup_if )
  );

  refill_ctrl i_ctrl (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .result          ( i_lookup_if     ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .mem_rsp_data_i  ( mem_rsp_data_i  ),
    .fill            ( i_fill_if       ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_data_o      ( rsp_data_o      ),
    .mem_req_o       ( mem_req_o       ),
    .mem_addr_o      ( mem_addr_o      )
  );

endmodule

// ==== dv/tb_clk_gen.sv ====
// Testbench clock source with a free-running square wave
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS = 10
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== dv/ro_cache_chk.sv ====
// Protocol assertions on the read-only cache top-level ports
`timescale 1ns/100ps

module ro_cache_chk (
  input logic clk_i,
  input logic reset_i,
  input logic req_valid_i,
  input logic rsp_valid_i,
  input logic mem_req_i,
  input logic mem_rsp_valid_i
);

  // Set from memory request until its answer
  logic        mem_pending_q;
  int unsigned assert_fail_count = 0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_pending_q <= 1'b0;
    end else if (mem_req_i) begin
      mem_pending_q <= 1'b1;
    end else if (mem_rsp_valid_i) begin
      mem_pending_q <= 1'b0;
    end
  end

  no_second_mem_req: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_i |-> !mem_pending_q)
    else begin
      $error("memory request issued while another one is unanswered");
      assert_fail_count++;
    end

  // First two cycles out of reset
  quiet_after_reset: assert property (@(posedge clk_i)
    (!reset_i && ($past(reset_i) || $past(reset_i, 2))) |-> !rsp_valid_i)
    else begin
      $error("response strobe seen right after reset");
      assert_fail_count++;
    end

  hit_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    $past(req_valid_i, 3) |-> (rsp_valid_i || mem_req_i))
    else begin
      $error("no response and no memory request 3 cycles after a read");
      assert_fail_count++;
    end

endmodule

// ==== dv/ro_cache_tb.sv ====
// Directed testbench for the read-only cache with a memory model on the refill port
`timescale 1ns/100ps

module ro_cache_tb
  import ro_cache_geom_pkg::*;
();

  localparam logic [DATA_W-1:0] MEM_PATTERN  = 32'h3c5a_a5c3;
  localparam logic [31:0]       LFSR_SEED    = 32'h5f7b;
  localparam logic [31:0]       LFSR_TAPS    = 32'h8020_0003;
  localparam logic [ADDR_W-1:0] REGION_START = 16'h0100;
  localparam logic [ADDR_W-1:0] REGION_END   = 16'h0200;
  // Same index with the next tag up
  localparam logic [ADDR_W-1:0] CONFLICT_A   = 16'h0189;
  localparam logic [ADDR_W-1:0] CONFLICT_B   = CONFLICT_A + (16'd1 << INDEX_W);
  localparam int unsigned       RSP_TIMEOUT  = 40;

  logic clk, reset, enable, flush, req_valid, mem_rsp_valid, rsp_valid, mem_req;
  logic [ADDR_W-1:0] region_start, region_end, req_addr, mem_addr;
  logic [DATA_W-1:0] mem_rsp_data, rsp_data;
  logic [31:0]       lfsr_state;
  int unsigned       mem_req_count;
  int unsigned       error_count;
  int unsigned       total_errors;

  tb_clk_gen #(.PERIOD_NS(10)) i_clk_gen (.clk_o(clk));

  ro_cache_top i_dut (
    .clk_i (clk), .reset_i (reset), .enable_i (enable), .flush_i (flush),
    .region_start_i (region_start), .region_end_i (region_end),
    .req_valid_i (req_valid), .req_addr_i (req_addr),
    .mem_rsp_valid_i (mem_rsp_valid), .mem_rsp_data_i (mem_rsp_data),
    .rsp_valid_o (rsp_valid), .rsp_data_o (rsp_data),
    .mem_req_o (mem_req), .mem_addr_o (mem_addr)
  );

  bind ro_cache_top ro_cache_chk i_chk (
    .clk_i (clk_i), .reset_i (reset_i), .req_valid_i (req_valid_i),
    .rsp_valid_i (rsp_valid_o), .mem_req_i (mem_req_o), .mem_rsp_valid_i (mem_rsp_valid_i)
  );

  // --------------------------------------
  // Memory model
  // --------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  // Whole address in both halves of the word
  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
    return {addr, addr} ^ MEM_PATTERN;
  endfunction

  // Three LFSR bits give 1 to 8 cycles
  task automatic draw_delay(output int unsigned delay);
    delay = 1;
    for (int i = 0; i < 3; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      if (lfsr_state[0]) begin
        delay = delay + (1 << i);
      end
    end
  endtask

  initial begin : mem_model
    int unsigned       delay;
    logic [ADDR_W-1:0] addr;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    mem_req_count = 0;
    lfsr_state    = LFSR_SEED;
    forever begin
      @(posedge clk);
      #1;
      if (mem_req) begin
        mem_req_count++;
        addr = mem_addr;
        draw_delay(delay);
        // Answer is sampled delay cycles after the request strobe
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        mem_rsp_valid = 1'b1;
        mem_rsp_data  = mem_word(addr);
        @(posedge clk);
        #1;
        mem_rsp_valid = 1'b0;
      end
    end
  end

  // --------------------------------------
  // Read with checks
  // --------------------------------------
  // Latency 0 means any latency is fine
  task automatic read_check(input logic [ADDR_W-1:0] addr, input int unsigned exp_reqs,
                            input int unsigned exp_latency);
    int unsigned start_count;
    int unsigned latency;
    @(posedge clk);
    #1;
    req_valid   = 1'b1;
    req_addr    = addr;
    start_count = mem_req_count;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    latency   = 1;
    while (!rsp_valid && latency < RSP_TIMEOUT) begin
      @(posedge clk);
      #1;
      latency++;
    end
    if (!rsp_valid) begin
      $display("Error: no response to the read of address %h within %0d cycles",
               addr, RSP_TIMEOUT);
      error_count++;
      return;
    end
    if (rsp_data !== mem_word(addr)) begin
      $display("Fail rsp_data_o at address %h: got %h, expected %h",
               addr, rsp_data, mem_word(addr));
      error_count++;
    end
    if (mem_req_count - start_count != exp_reqs) begin
      $display("Fail mem_req_o count at address %h: got %h, expected %h",
               addr, mem_req_count - start_count, exp_reqs);
      error_count++;
    end
    if (exp_latency != 0 && latency != exp_latency) begin
      $display("Fail rsp_valid_o latency at address %h: got %h, expected %h",
               addr, latency, exp_latency);
      error_count++;
    end
  endtask

  task automatic miss_then_hit();
    read_check(16'h0123, 1, 0);
    read_check(16'h0123, 0, 3);
  endtask

  task automatic region_bypass();
    read_check(REGION_START - 16'd1, 1, 0);
    read_check(REGION_START - 16'd1, 1, 0);
    read_check(REGION_END, 1, 0);
    read_check(REGION_END, 1, 0);
  endtask

  task automatic disable_and_reenable();
    enable = 1'b0;
    read_check(16'h0145, 1, 0);
    read_check(16'h0145, 1, 0);
    enable = 1'b1;
    read_check(16'h0145, 1, 0);
    read_check(16'h0145, 0, 3);
  endtask

  task automatic flush_invalidates();
    read_check(16'h0167, 1, 0);
    read_check(16'h0167, 0, 3);
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    read_check(16'h0167, 1, 0);
  endtask

  task automatic conflict_eviction();
    read_check(CONFLICT_A, 1, 0);
    read_check(CONFLICT_B, 1, 0);
    read_check(CONFLICT_A, 1, 0);
    read_check(CONFLICT_A, 0, 3);
  endtask

  initial begin
    reset        = 1'b1;
    enable       = 1'b1;
    flush        = 1'b0;
    req_valid    = 1'b0;
    req_addr     = '0;
    region_start = REGION_START;
    region_end   = REGION_END;
    error_count  = 0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    miss_then_hit();
    region_bypass();
    disable_and_reenable();
    flush_invalidates();
    conflict_eviction();
    repeat (4) @(posedge clk);
    total_errors = error_count + i_dut.i_chk.assert_fail_count;
    $display("Summary: %0d check errors, %0d assertion failures",
             error_count, i_dut.i_chk.assert_fail_count);
    if (total_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
design/ro_cache_geom_pkg.sv
design/ro_cache_ctrl_pkg.sv
design/lookup_if.sv
design/fill_if.sv
design/region_router.sv
design/line_store.sv
design/refill_ctrl.sv
design/ro_cache_top.sv
dv/tb_clk_gen.sv
dv/ro_cache_chk.sv
dv/ro_cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the read-only cache testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module ro_cache_tb \
  && { ./obj_dir/Vro_cache_tb +verilator+error+limit+100 > sim.log 2>&1 || true; } \
  && cat sim.log \
  && ! grep -q "TB FAILED" sim.log \
  && grep -q "TB PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
